// File: rtl/alu.sv
`default_nettype none

module alu import ex_pkg::*; (
   input  logic    [XLEN-1:0] op_a_i,
   input  logic    [XLEN-1:0] op_b_i,
   input  alu_op_e            alu_op_i,
   output logic    [XLEN-1:0] result_o
);

   logic [4:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;

   assign shamt       = op_b_i[4:0]; // RV32 shifts use 5 bits
   assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
   assign lt_unsigned = op_a_i < op_b_i;

   always_comb begin
      case (alu_op_i)
         ALU_ADD: begin
            result_o = op_a_i + op_b_i;
         end
         ALU_SUB: begin
            result_o = op_a_i - op_b_i;
         end
         ALU_SLL: begin
            result_o = op_a_i << shamt;
         end
         ALU_SLT: begin
            result_o = {{(XLEN-1){1'b0}}, lt_signed};
         end
         ALU_SLTU: begin
            result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
         end
         ALU_XOR: begin
            result_o = op_a_i ^ op_b_i;
         end
         ALU_SRL: begin
            result_o = op_a_i >> shamt;
         end
         ALU_SRA: begin
            // Sign bit shifted in
            result_o = $unsigned($signed(op_a_i) >>> shamt);
         end
         ALU_OR: begin
            result_o = op_a_i | op_b_i;
         end
         ALU_AND: begin
            result_o = op_a_i & op_b_i;
         end
         ALU_PASS_B: begin
            result_o = op_b_i;     // LUI immediate
         end
         default: begin
            result_o = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
`default_nettype none

module branch_unit import ex_pkg::*; (
   input  branch_op_e            branch_op_i,
   input  logic       [2:0]      funct3_i,
   input  logic       [XLEN-1:0] rs1_i,
   input  logic       [XLEN-1:0] rs2_i,
   input  logic       [XLEN-1:0] pc_i,
   input  logic       [XLEN-1:0] imm_i,
   output logic                  taken_o,
   output logic       [XLEN-1:0] target_o,
   output logic       [XLEN-1:0] link_o
);

   logic            cond_true;
   logic [XLEN-1:0] jalr_sum;

   always_comb begin
      case (funct3_i)
         F3_BEQ:  cond_true = rs1_i == rs2_i;
         F3_BNE:  cond_true = rs1_i != rs2_i;
         F3_BLT:  cond_true = $signed(rs1_i) < $signed(rs2_i);
         F3_BGE:  cond_true = $signed(rs1_i) >= $signed(rs2_i);
         F3_BLTU: cond_true = rs1_i < rs2_i;
         F3_BGEU: cond_true = rs1_i >= rs2_i;
         default: cond_true = 1'b0; // Reserved encodings never branch
      endcase
   end

   always_comb begin
      case (branch_op_i)
         BR_COND:         taken_o = cond_true;
         BR_JAL, BR_JALR: taken_o = 1'b1;
         default:         taken_o = 1'b0;
      endcase
   end

   assign jalr_sum = rs1_i + imm_i;

   // JALR drops the low bit of the sum
   assign target_o = (branch_op_i == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;
   assign link_o   = pc_i + 32'd4;

endmodule

`default_nettype wire

// File: rtl/ex_pkg.sv
`default_nettype none

package ex_pkg;

   localparam int XLEN = 32;

   ////////////////////////////////////////////////////
   // Operation encodings
   ////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_SLL    = 4'd2,
      ALU_SLT    = 4'd3,
      ALU_SLTU   = 4'd4,
      ALU_XOR    = 4'd5,
      ALU_SRL    = 4'd6,
      ALU_SRA    = 4'd7,
      ALU_OR     = 4'd8,
      ALU_AND    = 4'd9,
      ALU_PASS_B = 4'd10   // LUI
   } alu_op_e;

   // Same values as the M extension funct3
   typedef enum logic [2:0] {
      MDU_MUL    = 3'b000,
      MDU_MULH   = 3'b001,
      MDU_MULHSU = 3'b010,
      MDU_MULHU  = 3'b011,
      MDU_DIV    = 3'b100,
      MDU_DIVU   = 3'b101,
      MDU_REM    = 3'b110,
      MDU_REMU   = 3'b111
   } mdu_op_e;

   typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JAL, BR_JALR} branch_op_e;

   typedef enum logic {UNIT_ALU, UNIT_MDU} unit_sel_e;

   typedef enum logic [1:0] {FWD_REG, FWD_EX_MEM, FWD_MEM_WB} fwd_sel_e;

   // Conditional branch funct3
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none

module execute_stage import ex_pkg::*; #(
   parameter int MUL_STAGES = 2
) (
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic             valid_i,
   input  logic [XLEN-1:0]  pc_i,
   input  logic [XLEN-1:0]  imm_i,
   input  logic [4:0]       rs1_label_i,
   input  logic [4:0]       rs2_label_i,
   input  logic [4:0]       rd_label_i,
   input  logic [XLEN-1:0]  rs1_value_i,
   input  logic [XLEN-1:0]  rs2_value_i,
   input  logic             op_a_pc_i,
   input  logic             op_b_imm_i,
   input  unit_sel_e        unit_sel_i,
   input  alu_op_e          alu_op_i,
   input  mdu_op_e          mdu_op_i,
   input  branch_op_e       branch_op_i,
   input  logic [2:0]       funct3_i,
   input  logic             writes_rd_i,
   input  logic             is_load_i,
   input  logic             is_store_i,
   input  logic             wb_we_i,
   input  logic [4:0]       wb_rd_i,
   input  logic [XLEN-1:0]  wb_data_i,
   output logic             stall_o,
   output logic             valid_o,
   output logic [XLEN-1:0]  result_o,
   output logic [XLEN-1:0]  store_data_o,
   output logic [4:0]       rd_label_o,
   output logic             writes_rd_o,
   output logic             is_load_o,
   output logic             is_store_o,
   output logic [2:0]       funct3_o,
   output logic             branch_taken_o,
   output logic [XLEN-1:0]  branch_target_o
);

   fwd_sel_e        fwd_a;
   fwd_sel_e        fwd_b;
   logic [XLEN-1:0] rs1_fwd;
   logic [XLEN-1:0] rs2_fwd;
   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_res;
   logic [XLEN-1:0] mdu_res;
   logic [XLEN-1:0] link;
   logic [XLEN-1:0] target;
   logic [XLEN-1:0] ex_res;
   logic            br_taken;
   logic            mdu_req;
   logic            mdu_start;
   logic            mdu_busy;
   logic            mdu_done;
   logic            accept;

   function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e        sel,
                                               input logic [XLEN-1:0] reg_val,
                                               input logic [XLEN-1:0] ex_mem_val,
                                               input logic [XLEN-1:0] wb_val);
      case (sel)
         FWD_EX_MEM: return ex_mem_val;
         FWD_MEM_WB: return wb_val;
         default:    return reg_val;
      endcase
   endfunction

   ////////////////////////////////////////////////////
   // Operands
   ////////////////////////////////////////////////////

   // Only an EX/MEM entry that writes rd can forward
   forwarding_unit u_fwd (
      .rs1_label_i      (rs1_label_i),
      .rs2_label_i      (rs2_label_i),
      .ex_mem_valid_i   (valid_o && writes_rd_o),
      .ex_mem_rd_i      (rd_label_o),
      .ex_mem_is_load_i (is_load_o),
      .wb_we_i          (wb_we_i),
      .wb_rd_i          (wb_rd_i),
      .fwd_a_o          (fwd_a),
      .fwd_b_o          (fwd_b)
   );

   assign rs1_fwd = fwd_mux(fwd_a, rs1_value_i, result_o, wb_data_i);
   assign rs2_fwd = fwd_mux(fwd_b, rs2_value_i, result_o, wb_data_i);

   assign op_a = op_a_pc_i  ? pc_i  : rs1_fwd;  // AUIPC, JAL
   assign op_b = op_b_imm_i ? imm_i : rs2_fwd;

   ////////////////////////////////////////////////////
   // Units
   ////////////////////////////////////////////////////

   alu u_alu (
      .op_a_i   (op_a),
      .op_b_i   (op_b),
      .alu_op_i (alu_op_i),
      .result_o (alu_res)
   );

   branch_unit u_branch (
      .branch_op_i (branch_op_i),
      .funct3_i    (funct3_i),
      .rs1_i       (rs1_fwd),
      .rs2_i       (rs2_fwd),
      .pc_i        (pc_i),
      .imm_i       (imm_i),
      .taken_o     (br_taken),
      .target_o    (target),
      .link_o      (link)
   );

   // Slot behind a taken branch never reaches the MDU
   assign mdu_req   = valid_i && unit_sel_i == UNIT_MDU && !branch_taken_o;
   assign mdu_start = mdu_req && !mdu_busy;  // Busy marks the pending op

   mdu #(
      .MUL_STAGES (MUL_STAGES)
   ) u_mdu (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .start_i  (mdu_start),
      .mdu_op_i (mdu_op_i),
      .op_a_i   (op_a),
      .op_b_i   (op_b),
      .busy_o   (mdu_busy),
      .done_o   (mdu_done),
      .result_o (mdu_res)
   );

   always_comb begin
      if (unit_sel_i == UNIT_MDU)                                ex_res = mdu_res;
      else if (branch_op_i == BR_JAL || branch_op_i == BR_JALR) ex_res = link;
      else                                                       ex_res = alu_res;
   end

   // Held inputs are taken in the done cycle
   assign stall_o = mdu_req && !mdu_done;
   assign accept  = valid_i && !stall_o && !branch_taken_o;

   ////////////////////////////////////////////////////
   // EX/MEM register
   ////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_o        <= 1'b0;
         branch_taken_o <= 1'b0;
      end else begin
         valid_o        <= accept;               // Bubble while stalled
         branch_taken_o <= accept && br_taken;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         result_o        <= ex_res;
         store_data_o    <= rs2_fwd;
         rd_label_o      <= rd_label_i;
         writes_rd_o     <= writes_rd_i;
         is_load_o       <= is_load_i;
         is_store_o      <= is_store_i;
         funct3_o        <= funct3_i;
         branch_target_o <= target;
      end
   end

endmodule

`default_nettype wire

// File: rtl/forwarding_unit.sv
`default_nettype none

module forwarding_unit import ex_pkg::*; (
   input  logic     [4:0] rs1_label_i,
   input  logic     [4:0] rs2_label_i,
   input  logic           ex_mem_valid_i,
   input  logic     [4:0] ex_mem_rd_i,
   input  logic           ex_mem_is_load_i,
   input  logic           wb_we_i,
   input  logic     [4:0] wb_rd_i,
   output fwd_sel_e       fwd_a_o,
   output fwd_sel_e       fwd_b_o
);

   // Load data is not ready in EX/MEM yet
   logic ex_mem_fwd_ok;

   assign ex_mem_fwd_ok = ex_mem_valid_i && !ex_mem_is_load_i;

   function automatic fwd_sel_e pick_source(input logic [4:0] label,
                                            input logic       ex_ok,
                                            input logic [4:0] ex_rd,
                                            input logic       wb_we,
                                            input logic [4:0] wb_rd);
      if (label == 5'd0)
         return FWD_REG;    // x0 is hardwired
      else if (ex_ok && ex_rd == label)
         return FWD_EX_MEM; // Newest value wins
      else if (wb_we && wb_rd == label)
         return FWD_MEM_WB;
      else
         return FWD_REG;
   endfunction

   assign fwd_a_o = pick_source(rs1_label_i, ex_mem_fwd_ok, ex_mem_rd_i, wb_we_i, wb_rd_i);
   assign fwd_b_o = pick_source(rs2_label_i, ex_mem_fwd_ok, ex_mem_rd_i, wb_we_i, wb_rd_i);

endmodule

`default_nettype wire

// File: rtl/mdu.sv
`default_nettype none

module mdu import ex_pkg::*; #(
   parameter int MUL_STAGES = 2
) (
   input  logic            clk_i,
   input  logic            arst_n_i,
   input  logic            start_i,
   input  mdu_op_e         mdu_op_i,
   input  logic [XLEN-1:0] op_a_i,
   input  logic [XLEN-1:0] op_b_i,
   output logic            busy_o,
   output logic            done_o,
   output logic [XLEN-1:0] result_o
);

   localparam logic [5:0] DIV_STEPS = 6'(XLEN);

   logic is_div;

   assign is_div = mdu_op_i[2];

   ////////////////////////////////////////////////////
   // Multiplier
   ////////////////////////////////////////////////////

   logic                       a_signed;
   logic                       b_signed;
   logic signed [XLEN:0]       mul_a;
   logic signed [XLEN:0]       mul_b;
   logic signed [2*XLEN+1:0]   mul_prod;
   logic        [2*XLEN+1:0]   prod_q [MUL_STAGES];
   logic        [MUL_STAGES-1:0] mul_vld_q;
   logic        [MUL_STAGES-1:0] mul_hi_q;
   logic        [XLEN-1:0]     mul_res;

   assign a_signed = (mdu_op_i == MDU_MULH) || (mdu_op_i == MDU_MULHSU);
   assign b_signed = (mdu_op_i == MDU_MULH);

   // 33-bit operands cover all three signedness mixes
   assign mul_a    = {a_signed & op_a_i[XLEN-1], op_a_i};
   assign mul_b    = {b_signed & op_b_i[XLEN-1], op_b_i};
   assign mul_prod = mul_a * mul_b;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mul_vld_q <= '0;
      end else begin
         mul_vld_q[0] <= start_i && !is_div;
         for (int i = 1; i < MUL_STAGES; i++) begin
            mul_vld_q[i] <= mul_vld_q[i-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i && !is_div) begin
         prod_q[0]   <= mul_prod;
         mul_hi_q[0] <= mdu_op_i != MDU_MUL;
      end
      for (int i = 1; i < MUL_STAGES; i++) begin
         prod_q[i]   <= prod_q[i-1];
         mul_hi_q[i] <= mul_hi_q[i-1];
      end
   end

   assign mul_res = mul_hi_q[MUL_STAGES-1] ? prod_q[MUL_STAGES-1][2*XLEN-1:XLEN]
                                           : prod_q[MUL_STAGES-1][XLEN-1:0];

   ////////////////////////////////////////////////////
   // Restoring divider
   ////////////////////////////////////////////////////

   logic            div_signed;
   logic [XLEN-1:0] a_mag;
   logic [XLEN-1:0] b_mag;
   logic            div_active_q;
   logic [5:0]      div_cnt_q;
   logic [XLEN-1:0] rem_q;
   logic [XLEN-1:0] quo_q;      // Dividend bits out, quotient bits in
   logic [XLEN-1:0] divisor_q;
   logic            quo_neg_q;
   logic            rem_neg_q;
   logic            rem_sel_q;
   logic            div_zero_q;
   logic [XLEN:0]   shifted;
   logic [XLEN+1:0] diff;
   logic            div_done;
   logic [XLEN-1:0] div_res;

   assign div_signed = !mdu_op_i[0];
   assign a_mag      = (div_signed && op_a_i[XLEN-1]) ? -op_a_i : op_a_i;
   assign b_mag      = (div_signed && op_b_i[XLEN-1]) ? -op_b_i : op_b_i;

   assign shifted = {rem_q, quo_q[XLEN-1]};
   assign diff    = {1'b0, shifted} - {2'b00, divisor_q};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         div_active_q <= 1'b0;
         div_cnt_q    <= '0;
      end else if (start_i && is_div) begin
         div_active_q <= 1'b1;
         div_cnt_q    <= DIV_STEPS;
      end else if (div_active_q) begin
         if (div_cnt_q == '0) div_active_q <= 1'b0;
         else                 div_cnt_q    <= div_cnt_q - 6'd1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i && is_div) begin
         rem_q      <= '0;
         quo_q      <= a_mag;
         divisor_q  <= b_mag;
         quo_neg_q  <= div_signed && (op_a_i[XLEN-1] ^ op_b_i[XLEN-1]);
         rem_neg_q  <= div_signed && op_a_i[XLEN-1]; // Remainder follows dividend
         rem_sel_q  <= mdu_op_i[1];
         div_zero_q <= op_b_i == '0;
      end else if (div_active_q && div_cnt_q != '0) begin
         if (!diff[XLEN+1]) begin
            rem_q <= diff[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], 1'b1};
         end else begin
            rem_q <= shifted[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], 1'b0};
         end
      end
   end

   assign div_done = div_active_q && div_cnt_q == '0;

   // Divide by zero forces all ones; overflow falls out of the magnitudes
   always_comb begin
      if (rem_sel_q)       div_res = rem_neg_q ? -rem_q : rem_q;
      else if (div_zero_q) div_res = '1;
      else                 div_res = quo_neg_q ? -quo_q : quo_q;
   end

   assign busy_o   = (|mul_vld_q) || div_active_q;
   assign done_o   = mul_vld_q[MUL_STAGES-1] || div_done;
   assign result_o = mul_vld_q[MUL_STAGES-1] ? mul_res : div_res;

endmodule

`default_nettype wire

// File: sources.f
rtl/ex_pkg.sv
rtl/forwarding_unit.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/mdu.sv
rtl/execute_stage.sv
tests/execute_stage_assertions.sv
tests/tb_execute_stage.sv

// File: tests/execute_stage_assertions.sv
`default_nettype none

module execute_stage_assertions (
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic stall_i,
   input  logic ex_valid_i,
   input  logic taken_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // EX/MEM flags are cleared by the async reset
   reset_clears_flags: assert property (@(posedge clk_i) !arst_n_i |-> !ex_valid_i && !taken_i)
      else $error("valid_o or branch_taken_o high during reset");

   taken_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      taken_i |=> !taken_i)
      else $error("branch_taken_o held longer than one cycle");

   // Held MDU instruction lands in EX/MEM once the stall drops
   stall_release_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      stall_i ##1 !stall_i |=> ex_valid_i)
      else $error("valid_o missing after the stall ended");

endmodule

bind execute_stage execute_stage_assertions u_assertions (
   .clk_i      (clk_i),
   .arst_n_i   (arst_n_i),
   .stall_i    (stall_o),
   .ex_valid_i (valid_o),
   .taken_i    (branch_taken_o)
);

`default_nettype wire

// File: tests/tb_execute_stage.sv
`default_nettype none

module tb_execute_stage
   import ex_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MUL_STAGES     = 3;
   localparam int NUM_INSTR      = 300;
   localparam int RESET_CYCLES   = 8;
   localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + RESET_CYCLES;

   typedef struct packed {
      logic [XLEN-1:0] result;
      logic [XLEN-1:0] store;
      logic [XLEN-1:0] target;
      logic [XLEN-1:0] due;      // Cycle count when valid_o is seen
      logic [4:0]      rd;
      logic [2:0]      f3;
      logic            writes;
      logic            is_load;
      logic            is_store;
      logic            taken;
      logic            is_branch;
      logic            check_store;
   } exp_t;

   logic clk_i;
   logic arst_n_i;
   logic valid_i;
   logic [XLEN-1:0] pc_i;
   logic [XLEN-1:0] imm_i;
   logic [4:0] rs1_label_i;
   logic [4:0] rs2_label_i;
   logic [4:0] rd_label_i;
   logic [XLEN-1:0] rs1_value_i;
   logic [XLEN-1:0] rs2_value_i;
   logic op_a_pc_i;
   logic op_b_imm_i;
   unit_sel_e unit_sel_i;
   alu_op_e alu_op_i;
   mdu_op_e mdu_op_i;
   branch_op_e branch_op_i;
   logic [2:0] funct3_i;
   logic writes_rd_i;
   logic is_load_i;
   logic is_store_i;
   logic wb_we_i;
   logic [4:0] wb_rd_i;
   logic [XLEN-1:0] wb_data_i;
   logic stall_o;
   logic valid_o;
   logic [XLEN-1:0] result_o;
   logic [XLEN-1:0] store_data_o;
   logic [4:0] rd_label_o;
   logic writes_rd_o;
   logic is_load_o;
   logic is_store_o;
   logic [2:0] funct3_o;
   logic branch_taken_o;
   logic [XLEN-1:0] branch_target_o;

   // Next instruction and the wb write that goes with it
   logic [XLEN-1:0] ins_pc, ins_imm, ins_rs1_val, ins_rs2_val, ins_wb_data;
   logic [4:0] ins_rs1, ins_rs2, ins_rd, ins_wb_rd;
   logic ins_a_pc, ins_b_imm, ins_wr, ins_load, ins_store, ins_wb_we;
   logic [2:0] ins_f3;
   unit_sel_e ins_unit;
   alu_op_e ins_alu;
   mdu_op_e ins_mdu;
   branch_op_e ins_br;

   // Shadow of the EX/MEM register as the next instruction sees it
   logic sh_valid, sh_wr, sh_load, sh_taken;
   logic [4:0] sh_rd;
   logic [XLEN-1:0] sh_result;

   logic [31:0] lfsr_state = 32'h8669_c33a;
   int unsigned cycles = 0;
   exp_t exp_q[$];

   execute_stage #(
      .MUL_STAGES (MUL_STAGES)
   ) dut (
      .clk_i (clk_i), .arst_n_i (arst_n_i), .valid_i (valid_i),
      .pc_i (pc_i), .imm_i (imm_i),
      .rs1_label_i (rs1_label_i), .rs2_label_i (rs2_label_i), .rd_label_i (rd_label_i),
      .rs1_value_i (rs1_value_i), .rs2_value_i (rs2_value_i),
      .op_a_pc_i (op_a_pc_i), .op_b_imm_i (op_b_imm_i), .unit_sel_i (unit_sel_i),
      .alu_op_i (alu_op_i), .mdu_op_i (mdu_op_i), .branch_op_i (branch_op_i),
      .funct3_i (funct3_i), .writes_rd_i (writes_rd_i),
      .is_load_i (is_load_i), .is_store_i (is_store_i),
      .wb_we_i (wb_we_i), .wb_rd_i (wb_rd_i), .wb_data_i (wb_data_i),
      .stall_o (stall_o), .valid_o (valid_o), .result_o (result_o),
      .store_data_o (store_data_o), .rd_label_o (rd_label_o),
      .writes_rd_o (writes_rd_o), .is_load_o (is_load_o), .is_store_o (is_store_o),
      .funct3_o (funct3_o), .branch_taken_o (branch_taken_o),
      .branch_target_o (branch_target_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r          = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
         $display("Result: FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   ////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////

   function automatic logic [31:0] fwd_value(input logic [4:0] label, input logic [31:0] reg_val);
      if (label == 5'd0) return reg_val;
      if (sh_valid && sh_wr && !sh_load && sh_rd == label) return sh_result;
      if (ins_wb_we && ins_wb_rd == label) return ins_wb_data;
      return reg_val;
   endfunction

   function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_SLL:  return a << b[4:0];
         ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
         ALU_SLTU: return {31'd0, a < b};
         ALU_XOR:  return a ^ b;
         ALU_SRL:  return a >> b[4:0];
         ALU_SRA:  return $signed(a) >>> b[4:0];
         ALU_OR:   return a | b;
         ALU_AND:  return a & b;
         default:  return b;   // PASS_B
      endcase
   endfunction

   function automatic logic [31:0] mdu_ref(input mdu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
      logic [63:0] ss;
      logic [63:0] su;
      logic [63:0] uu;
      logic        ovf;
      ss  = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      su  = {{32{a[31]}}, a} * {32'd0, b};
      uu  = {32'd0, a} * {32'd0, b};
      ovf = a == 32'h8000_0000 && b == 32'hffff_ffff;
      case (op)
         MDU_MUL:    return uu[31:0];
         MDU_MULH:   return ss[63:32];
         MDU_MULHSU: return su[63:32];
         MDU_MULHU:  return uu[63:32];
         MDU_DIV: begin
            if (b == 0) return 32'hffff_ffff;
            if (ovf) return a;
            return $signed(a) / $signed(b);
         end
         MDU_DIVU:   return (b == 0) ? 32'hffff_ffff : a / b;
         MDU_REM: begin
            if (b == 0) return a;
            if (ovf) return 32'd0;
            return $signed(a) % $signed(b);
         end
         default:    return (b == 0) ? a : a % b;
      endcase
   endfunction

   function automatic exp_t expected_of();
      exp_t        e;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] a;
      logic [31:0] b;
      r1 = fwd_value(ins_rs1, ins_rs1_val);
      r2 = fwd_value(ins_rs2, ins_rs2_val);
      a  = ins_a_pc ? ins_pc : r1;
      b  = ins_b_imm ? ins_imm : r2;
      e  = '0;
      e.rd          = ins_rd;
      e.f3          = ins_f3;
      e.writes      = ins_wr;
      e.is_load     = ins_load;
      e.is_store    = ins_store;
      e.store       = r2;
      e.check_store = ins_unit == UNIT_ALU;   // Store data of an MDU op is taken late
      e.is_branch   = ins_br != BR_NONE;
      e.target      = ins_pc + ins_imm;
      case (ins_br)
         BR_COND: begin
            case (ins_f3)
               F3_BEQ:  e.taken = r1 == r2;
               F3_BNE:  e.taken = r1 != r2;
               F3_BLT:  e.taken = $signed(r1) < $signed(r2);
               F3_BGE:  e.taken = $signed(r1) >= $signed(r2);
               F3_BLTU: e.taken = r1 < r2;
               default: e.taken = r1 >= r2;
            endcase
         end
         BR_JAL:  e.taken = 1'b1;
         BR_JALR: begin
            e.taken  = 1'b1;
            e.target = (r1 + ins_imm) & ~32'd1;
         end
         default: e.taken = 1'b0;
      endcase
      if (ins_unit == UNIT_MDU)                      e.result = mdu_ref(ins_mdu, a, b);
      else if (ins_br == BR_JAL || ins_br == BR_JALR) e.result = ins_pc + 32'd4;
      else                                           e.result = alu_ref(ins_alu, a, b);
      return e;
   endfunction

   ////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////

   task automatic gen_instr();
      logic [2:0] kind;
      kind        = 3'(rand_bits(3));
      ins_pc      = {30'(rand_bits(30)), 2'b00};
      ins_imm     = rand_bits(32);
      ins_rs1     = 5'(rand_bits(3));   // Small label set makes hazards common
      ins_rs2     = 5'(rand_bits(3));
      ins_rs1_val = (ins_rs1 == 0) ? 32'd0 : rand_bits(32);
      ins_rs2_val = (ins_rs2 == 0) ? 32'd0 : rand_bits(32);
      ins_rd      = 5'(rand_bits(3));
      ins_a_pc    = 1'b0;
      ins_b_imm   = 1'(rand_bits(1));
      ins_wr      = 1'b1;
      ins_load    = 1'b0;
      ins_store   = 1'b0;
      ins_unit    = UNIT_ALU;
      ins_alu     = ALU_ADD;
      ins_mdu     = MDU_MUL;
      ins_br      = BR_NONE;
      ins_f3      = 3'(rand_bits(3));
      ins_wb_we   = 1'(rand_bits(1));
      ins_wb_rd   = 5'(rand_bits(3));
      ins_wb_data = rand_bits(32);
      case (kind)
         3'd0, 3'd1, 3'd2: begin
            ins_alu  = alu_op_e'(4'(rand_bits(4) % 11));
            ins_a_pc = rand_bits(2) == 0;    // AUIPC style
         end
         3'd3: begin
            ins_load  = 1'(rand_bits(1));
            ins_store = !ins_load;
            ins_b_imm = 1'b1;
            if (ins_store) begin
               ins_wr = 1'b0;   // rd label stays random but is never written
            end
         end
         3'd4, 3'd5: begin
            ins_unit  = UNIT_MDU;
            ins_b_imm = 1'b0;
            ins_mdu   = mdu_op_e'(3'(rand_bits(3)));
            if (rand_bits(3) == 0) begin
               // Overflow operands on labels nothing writes
               ins_rs1     = 5'd8;
               ins_rs2     = 5'd9;
               ins_rs1_val = 32'h8000_0000;
               ins_rs2_val = 32'hffff_ffff;
            end
         end
         3'd6: begin
            ins_br    = BR_COND;
            ins_alu   = ALU_SUB;
            ins_b_imm = 1'b0;
            ins_wr    = 1'b0;
            if (ins_f3[2:1] == 2'b01) ins_f3[1] = 1'b0;  // Skip reserved funct3
         end
         default: begin
            ins_br = rand_bits(1) ? BR_JALR : BR_JAL;
         end
      endcase
   endtask

   task automatic drive_instr();
      valid_i     <= 1'b1;
      pc_i        <= ins_pc;
      imm_i       <= ins_imm;
      rs1_label_i <= ins_rs1;
      rs2_label_i <= ins_rs2;
      rd_label_i  <= ins_rd;
      rs1_value_i <= ins_rs1_val;
      rs2_value_i <= ins_rs2_val;
      op_a_pc_i   <= ins_a_pc;
      op_b_imm_i  <= ins_b_imm;
      unit_sel_i  <= ins_unit;
      alu_op_i    <= ins_alu;
      mdu_op_i    <= ins_mdu;
      branch_op_i <= ins_br;
      funct3_i    <= ins_f3;
      writes_rd_i <= ins_wr;
      is_load_i   <= ins_load;
      is_store_i  <= ins_store;
      wb_we_i     <= ins_wb_we;
      wb_rd_i     <= ins_wb_rd;
      wb_data_i   <= ins_wb_data;
   endtask

   initial begin
      exp_t e;
      arst_n_i    = 1'b1;
      valid_i     = 1'b0;
      pc_i        = '0;
      imm_i       = '0;
      rs1_label_i = '0;
      rs2_label_i = '0;
      rd_label_i  = '0;
      rs1_value_i = '0;
      rs2_value_i = '0;
      op_a_pc_i   = 1'b0;
      op_b_imm_i  = 1'b0;
      unit_sel_i  = UNIT_ALU;
      alu_op_i    = ALU_ADD;
      mdu_op_i    = MDU_MUL;
      branch_op_i = BR_NONE;
      funct3_i    = '0;
      writes_rd_i = 1'b0;
      is_load_i   = 1'b0;
      is_store_i  = 1'b0;
      wb_we_i     = 1'b0;
      wb_rd_i     = '0;
      wb_data_i   = '0;
      sh_valid    = 1'b0;
      sh_taken    = 1'b0;
      #1 arst_n_i = 1'b0;   // Falling edge after time zero
      repeat (RESET_CYCLES) @(posedge clk_i);
      arst_n_i <= 1'b1;

      for (int n = 0; n < NUM_INSTR; n++) begin
         if (rand_bits(3) == 0) begin
            @(posedge clk_i);
            valid_i  <= 1'b0;            // Bubble
            wb_we_i  <= 1'b0;
            sh_valid  = 1'b0;
            sh_taken  = 1'b0;
         end
         gen_instr();
         @(posedge clk_i);
         drive_instr();
         if (sh_taken) begin
            // Slot behind a taken branch is dropped
            sh_valid = 1'b0;
            sh_taken = 1'b0;
            @(negedge clk_i);
            check_value("stall_o", stall_o, 1'b0);
         end else begin
            e     = expected_of();
            e.due = cycles + 2;
            if (ins_unit == UNIT_MDU) begin
               @(negedge clk_i);
               check_value("stall_o", stall_o, 1'b1);
               while (stall_o) @(negedge clk_i);
               e.due = cycles + 1;
            end
            exp_q.push_back(e);
            sh_valid  = 1'b1;
            sh_wr     = ins_wr;
            sh_load   = ins_load;
            sh_rd     = ins_rd;
            sh_result = e.result;
            sh_taken  = e.taken;
         end
      end

      @(posedge clk_i);
      valid_i <= 1'b0;
      wb_we_i <= 1'b0;
      repeat (4) @(negedge clk_i);
      if (exp_q.size() != 0) begin
         $display("%0d instructions never reached the EX/MEM register", exp_q.size());
         $display("Result: FAILED");
         $fatal(1, "missing EX/MEM entries");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////
   // Compare and timeout
   ////////////////////////////////////////////////////

   always @(negedge clk_i) begin : compare_outputs
      exp_t e;
      if (arst_n_i && (valid_o === 1'b1 || branch_taken_o === 1'b1)) begin
         if (exp_q.size() == 0) begin
            $display("EX/MEM output rose with no instruction outstanding");
            $display("Result: FAILED");
            $fatal(1, "unexpected EX/MEM entry");
         end else begin
            e = exp_q.pop_front();
            check_value("valid_o", valid_o, 1'b1);
            check_value("valid_o cycle", cycles, e.due);
            check_value("result_o", result_o, e.result);
            check_value("rd_label_o", rd_label_o, e.rd);
            check_value("writes_rd_o", writes_rd_o, e.writes);
            check_value("is_load_o", is_load_o, e.is_load);
            check_value("is_store_o", is_store_o, e.is_store);
            check_value("funct3_o", funct3_o, e.f3);
            check_value("branch_taken_o", branch_taken_o, e.taken);
            if (e.is_branch) check_value("branch_target_o", branch_target_o, e.target);
            if (e.check_store) check_value("store_data_o", store_data_o, e.store);
         end
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles with no end of test", TIMEOUT_CYCLES);
         $display("Result: FAILED");
         $fatal(1, "timeout");
      end
   end

endmodule

`default_nettype wire
